// File: hdl/savePkg.sv
/*
  Shared widths, sector counts and the system-type enumeration
  for the save-storage and reset-sequencing block
*/

package savePkg;

	// ========================================
	// System type
	// ========================================

	// Top bit set means a CD based system
	// Arcade is the MVS with battery backed RAM
	typedef enum logic [1:0]
	{
		sysConsole = 2'd0,
		sysArcade  = 2'd1,
		sysCd      = 2'd2,
		sysCdz     = 2'd3
	} sysTypeT;

	// ========================================
	// Widths
	// ========================================

	// Word address inside one 256-word host sector
	localparam int BuffAddrW = 8;

	// All save memories hold 16-bit words
	localparam int WordW = 16;

	// Host block address
	localparam int LbaW = 32;

	// Card is 16 sectors of 256 words
	localparam int CardAddrW = 12;

	// Backup RAM is 128 sectors of 256 words
	localparam int BackupAddrW = 15;

	// ========================================
	// Save file layout
	// ========================================

	// Cartridge file, backup RAM followed by the card
	localparam int CartSectors = 132;

	// CD file, card only
	localparam int CdSectors = 16;

	// Sectors below this go to backup RAM on cartridge systems
	localparam int BackupSectors = 128;

endpackage

// File: hdl/saveRam.sv
/*
  Dual-port save memory
  CPU port with byte enables, host sector buffer port
*/

`timescale 1ns/1ps

module saveRam
#(
	parameter int AddrW = 15
)
(
	input  logic                      clk_sys,
	input  logic [AddrW-1:0]          cpuAddr,
	input  logic                      cpuWrLo,
	input  logic                      cpuWrHi,
	input  logic [savePkg::WordW-1:0] cpuDin,
	output logic [savePkg::WordW-1:0] cpuDout,
	input  logic [AddrW-1:0]          bufAddr,
	input  logic                      bufWr,
	input  logic [savePkg::WordW-1:0] bufDin,
	output logic [savePkg::WordW-1:0] bufDout
);

	import savePkg::*;

	localparam int ByteW = WordW / 2;

	logic [WordW-1:0] mem [2**AddrW];

	always_ff @(posedge clk_sys)
	begin
		// CPU side, per byte lane
		if (cpuWrLo)
			mem[cpuAddr][ByteW-1:0] <= cpuDin[ByteW-1:0];
		if (cpuWrHi)
			mem[cpuAddr][WordW-1:ByteW] <= cpuDin[WordW-1:ByteW];
		// Buffer side last, so it wins a same-word collision
		if (bufWr)
			mem[bufAddr] <= bufDin;

		// Both reads registered
		cpuDout <= mem[cpuAddr];
		bufDout <= mem[bufAddr];
	end

endmodule

// File: hdl/resetWiper.sv
/*
  Reset request edge detection, work RAM wipe counter,
  system-type latch and system run output
*/

`timescale 1ns/1ps

module resetWiper
#(
	parameter int WramAddrW = 15
)
(
	input  logic                 clk_sys,
	input  logic                 nBNKB,
	input  logic                 sysResetReq,
	input  savePkg::sysTypeT     systemType,
	output logic                 sysRunning,
	output logic                 wipeActive,
	output logic [WramAddrW-1:0] wipeAddr,
	output savePkg::sysTypeT     sysType
);

	import savePkg::*;

	logic reqPrev;
	logic reqRise;
	logic reqFall;
	logic wipeLast;

	assign reqRise  = sysResetReq & ~reqPrev;
	assign reqFall  = ~sysResetReq & reqPrev;
	assign wipeLast = (wipeAddr == {WramAddrW{1'b1}});

	// Wipe runs straight out of reset, system held until it ends
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			reqPrev    <= 1'b0;
			sysRunning <= 1'b0;
			wipeActive <= 1'b1;
			wipeAddr   <= '0;
		end
		else
		begin
			reqPrev <= sysResetReq;

			// Request start puts the system in reset
			if (reqRise)
				sysRunning <= 1'b0;

			// Request end restarts the wipe from the bottom
			if (reqFall)
			begin
				wipeActive <= 1'b1;
				wipeAddr   <= '0;
				sysRunning <= 1'b0;
			end
			else if (wipeActive)
			begin
				if (wipeLast)
				begin
					// Last word written, release unless a new request is up
					wipeActive <= 1'b0;
					sysRunning <= ~sysResetReq;
				end
				else
					wipeAddr <= wipeAddr + 1'b1;
			end
		end
	end

	// System type sampled on the first word of each wipe
	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
			sysType <= sysConsole;
		else if (wipeActive && (wipeAddr == '0))
			sysType <= systemType;
	end

endmodule

// File: hdl/workRam.sv
/*
  68k work RAM, two byte-lane arrays
  with the wipe write path muxed over the CPU port
*/

`timescale 1ns/1ps

module workRam
#(
	parameter int WramAddrW = 15
)
(
	input  logic                      clk_sys,
	input  logic                      wipeActive,
	input  logic [WramAddrW-1:0]      wipeAddr,
	input  logic [WramAddrW-1:0]      cpuAddr,
	input  logic                      cpuWrLo,
	input  logic                      cpuWrHi,
	input  logic [savePkg::WordW-1:0] cpuDin,
	output logic [savePkg::WordW-1:0] cpuDout
);

	import savePkg::*;

	localparam int ByteW = WordW / 2;

	logic [ByteW-1:0]     loMem [2**WramAddrW];
	logic [ByteW-1:0]     hiMem [2**WramAddrW];

	logic [WramAddrW-1:0] ramAddr;
	logic [WordW-1:0]     ramDin;
	logic                 wrLo;
	logic                 wrHi;

	// Wipe owns the RAM, CPU writes dropped meanwhile
	assign ramAddr = wipeActive ? wipeAddr : cpuAddr;
	// Each word gets its own address as fill pattern
	assign ramDin  = wipeActive ? WordW'(wipeAddr) : cpuDin;
	assign wrLo    = wipeActive | cpuWrLo;
	assign wrHi    = wipeActive | cpuWrHi;

	always_ff @(posedge clk_sys)
	begin
		if (wrLo)
			loMem[ramAddr] <= ramDin[ByteW-1:0];
		if (wrHi)
			hiMem[ramAddr] <= ramDin[WordW-1:ByteW];
		// Registered read, one cycle latency
		cpuDout <= {hiMem[ramAddr], loMem[ramAddr]};
	end

endmodule

// File: hdl/saveSequencer.sv
/*
  Save file sequencer
  Load/save control, host request handshake, LBA counter,
  sector buffer write routing and readback select
*/

`timescale 1ns/1ps

module saveSequencer
(
	input  logic                            clk_sys,
	input  logic                            nBNKB,
	input  savePkg::sysTypeT                sysType,

	input  logic                            downloading,
	input  logic                            imgReady,
	input  logic                            saveReq,

	input  logic                            sdAck,
	input  logic [savePkg::BuffAddrW-1:0]   sdBuffAddr,
	input  logic                            sdBuffWr,
	output logic [savePkg::LbaW-1:0]        sdLba,
	output logic                            sdRd,
	output logic                            sdWr,
	output logic [savePkg::WordW-1:0]       sdBuffDin,

	input  logic                            bkCpuWrLo,
	input  logic                            bkCpuWrHi,
	output logic                            bkWrLoGated,
	output logic                            bkWrHiGated,

	output logic [savePkg::BackupAddrW-1:0] bkBufAddr,
	output logic                            bkBufWr,
	input  logic [savePkg::WordW-1:0]       bkBufDout,

	output logic [savePkg::CardAddrW-1:0]   cardBufAddr,
	output logic                            cardBufWr,
	input  logic [savePkg::WordW-1:0]       cardBufDout
);

	import savePkg::*;

	// LBA bit splitting backup RAM from card on cartridge systems
	localparam int CardBit = $clog2(BackupSectors);

	logic            dlPrev;
	logic            saveReqPrev;
	logic            ackPrev;
	logic            xferEna;
	logic            loadPend;
	logic            busy;
	logic            loading;

	logic            isCd;
	logic            isMvs;
	logic            cardSel;
	logic            ackRise;
	logic            ackFall;
	logic            saveRise;
	logic [LbaW-1:0] lastLba;

	assign isCd     = sysType[1];
	assign isMvs    = (sysType == sysArcade);
	assign ackRise  = sdAck & ~ackPrev;
	assign ackFall  = ~sdAck & ackPrev;
	assign saveRise = saveReq & ~saveReqPrev;
	assign lastLba  = isCd ? LbaW'(CdSectors - 1) : LbaW'(CartSectors - 1);

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge clk_sys or negedge nBNKB)
	begin
		if (!nBNKB)
		begin
			dlPrev      <= 1'b0;
			saveReqPrev <= 1'b0;
			ackPrev     <= 1'b0;
			xferEna     <= 1'b0;
			loadPend    <= 1'b0;
			busy        <= 1'b0;
			loading     <= 1'b0;
			sdLba       <= '0;
			sdRd        <= 1'b0;
			sdWr        <= 1'b0;
		end
		else
		begin
			dlPrev      <= downloading;
			saveReqPrev <= saveReq;
			ackPrev     <= sdAck;

			// Off from download start, on once an image is ready
			xferEna <= ~downloading & imgReady;

			// Download end arms a load, dropped once it starts
			if (dlPrev & ~downloading)
				loadPend <= 1'b1;
			else if (busy)
				loadPend <= 1'b0;

			if (ackRise)
			begin
				// Host took the request
				sdRd <= 1'b0;
				sdWr <= 1'b0;
			end
			else if (!busy)
			begin
				if (xferEna & (loadPend | saveRise))
				begin
					busy    <= 1'b1;
					loading <= loadPend;
					sdLba   <= '0;
					sdRd    <= loadPend;
					sdWr    <= ~loadPend;
				end
			end
			else if (ackFall)
			begin
				// Sector done, stop at the end of the file
				if (sdLba >= lastLba)
					busy <= 1'b0;
				else
				begin
					sdLba <= sdLba + 1'b1;
					sdRd  <= loading;
					sdWr  <= ~loading;
				end
			end
		end
	end

	// ========================================
	// Buffer routing
	// ========================================

	// Card on CD systems, or upper sectors of a cartridge file
	assign cardSel = isCd | sdLba[CardBit];

	// Backup RAM only exists on MVS
	assign bkBufWr   = isMvs & ~sdLba[CardBit] & sdBuffWr & sdAck;
	assign cardBufWr = cardSel & sdBuffWr & sdAck;

	// Sector number on top of the word offset
	assign bkBufAddr   = {sdLba[BackupAddrW-BuffAddrW-1:0], sdBuffAddr};
	assign cardBufAddr = {sdLba[CardAddrW-BuffAddrW-1:0], sdBuffAddr};

	// Save readback, memories already one cycle behind the address
	assign sdBuffDin = cardSel ? cardBufDout : bkBufDout;

	// CPU writes to backup RAM ignored on other systems
	assign bkWrLoGated = bkCpuWrLo & isMvs;
	assign bkWrHiGated = bkCpuWrHi & isMvs;

endmodule

// File: hdl/saveStoreTop.sv
/*
  Top level of the save-storage block
  Reset wiper, work RAM, save/load sequencer,
  backup RAM and memory card instances
*/

`timescale 1ns/1ps

module saveStoreTop
#(
	parameter int WramAddrW = 15
)
(
	input  logic                               clk_sys,
	input  logic                               nBNKB,

	input  logic                               sysResetReq,
	input  savePkg::sysTypeT                   systemType,
	output logic                               sysRunning,

	// 68k work RAM
	input  logic [WramAddrW-1:0]               wramAddr,
	input  logic                               wramWrLo,
	input  logic                               wramWrHi,
	input  logic [savePkg::WordW-1:0]          wramDin,
	output logic [savePkg::WordW-1:0]          wramDout,

	// Backup RAM, CPU side
	input  logic [savePkg::BackupAddrW-1:0]    bkAddr,
	input  logic                               bkWrLo,
	input  logic                               bkWrHi,
	input  logic [savePkg::WordW-1:0]          bkDin,
	output logic [savePkg::WordW-1:0]          bkDout,

	// Memory card, CPU side
	input  logic [savePkg::CardAddrW-1:0]      cardAddr,
	input  logic                               cardWr,
	input  logic [savePkg::WordW-1:0]          cardDin,
	output logic [savePkg::WordW-1:0]          cardDout,

	// Save file triggers
	input  logic                               downloading,
	input  logic                               imgReady,
	input  logic                               saveReq,

	// Host block device
	output logic [savePkg::LbaW-1:0]           sdLba,
	output logic                               sdRd,
	output logic                               sdWr,
	input  logic                               sdAck,
	input  logic [savePkg::BuffAddrW-1:0]      sdBuffAddr,
	input  logic [savePkg::WordW-1:0]          sdBuffDout,
	input  logic                               sdBuffWr,
	output logic [savePkg::WordW-1:0]          sdBuffDin
);

	import savePkg::*;

	// Wiper outputs
	logic                   wipeActive;
	logic [WramAddrW-1:0]   wipeAddr;
	sysTypeT                sysType;

	// Backup CPU writes after the MVS gate
	logic                   bkWrLoGated;
	logic                   bkWrHiGated;

	// Sector buffer ports
	logic [BackupAddrW-1:0] bkBufAddr;
	logic                   bkBufWr;
	logic [WordW-1:0]       bkBufDout;
	logic [CardAddrW-1:0]   cardBufAddr;
	logic                   cardBufWr;
	logic [WordW-1:0]       cardBufDout;

	resetWiper #(.WramAddrW(WramAddrW)) wiper
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.sysResetReq(sysResetReq), .systemType(systemType),
		.sysRunning(sysRunning),
		.wipeActive(wipeActive), .wipeAddr(wipeAddr),
		.sysType(sysType)
	);

	workRam #(.WramAddrW(WramAddrW)) wram
	(
		.clk_sys(clk_sys),
		.wipeActive(wipeActive), .wipeAddr(wipeAddr),
		.cpuAddr(wramAddr), .cpuWrLo(wramWrLo), .cpuWrHi(wramWrHi),
		.cpuDin(wramDin), .cpuDout(wramDout)
	);

	saveSequencer sequencer
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB), .sysType(sysType),
		.downloading(downloading), .imgReady(imgReady), .saveReq(saveReq),
		.sdAck(sdAck), .sdBuffAddr(sdBuffAddr), .sdBuffWr(sdBuffWr),
		.sdLba(sdLba), .sdRd(sdRd), .sdWr(sdWr), .sdBuffDin(sdBuffDin),
		.bkCpuWrLo(bkWrLo), .bkCpuWrHi(bkWrHi),
		.bkWrLoGated(bkWrLoGated), .bkWrHiGated(bkWrHiGated),
		.bkBufAddr(bkBufAddr), .bkBufWr(bkBufWr), .bkBufDout(bkBufDout),
		.cardBufAddr(cardBufAddr), .cardBufWr(cardBufWr), .cardBufDout(cardBufDout)
	);

	// Battery backed RAM, MVS only
	saveRam #(.AddrW(BackupAddrW)) backupRam
	(
		.clk_sys(clk_sys),
		.cpuAddr(bkAddr), .cpuWrLo(bkWrLoGated), .cpuWrHi(bkWrHiGated),
		.cpuDin(bkDin), .cpuDout(bkDout),
		.bufAddr(bkBufAddr), .bufWr(bkBufWr),
		.bufDin(sdBuffDout), .bufDout(bkBufDout)
	);

	// Card is written a whole word at a time
	saveRam #(.AddrW(CardAddrW)) cardRam
	(
		.clk_sys(clk_sys),
		.cpuAddr(cardAddr), .cpuWrLo(cardWr), .cpuWrHi(cardWr),
		.cpuDin(cardDin), .cpuDout(cardDout),
		.bufAddr(cardBufAddr), .bufWr(cardBufWr),
		.bufDin(sdBuffDout), .bufDout(cardBufDout)
	);

endmodule

// File: testbench/tbClock.sv
/*
  Testbench clock source
  Free running clk_sys, 4 ns period
*/

`timescale 1ns/1ps

module tbClock
#(
	parameter int HalfPeriod = 2
)
(
	output logic clk_sys
);

	// Starts low, first rising edge after one half period
	initial
	begin
		clk_sys = 1'b0;
		forever #(HalfPeriod) clk_sys = ~clk_sys;
	end

endmodule

// File: testbench/saveStore_asserts.sv
/*
  Concurrent checks on the sequencer host handshake
  Bound into every saveSequencer instance
*/

`timescale 1ns/1ps

module saveStore_asserts
(
	input logic                     clk_sys,
	input logic                     nBNKB,
	input logic                     sdRd,
	input logic                     sdWr,
	input logic                     sdAck,
	input logic [savePkg::LbaW-1:0] sdLba
);

	// A load and a save never overlap
	reqExclusive: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		!(sdRd && sdWr))
		else $error("sdRd and sdWr are high in the same cycle");

	// Host acknowledge takes the request down on the next edge
	reqDropOnAck: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		$rose(sdAck) |=> !(sdRd || sdWr))
		else $error("Request still high after the rising sdAck");

	// Block address held while a request waits for the host
	lbaStable: assert property (@(posedge clk_sys) disable iff (!nBNKB)
		($past(sdRd || sdWr) && (sdRd || sdWr)) |-> $stable(sdLba))
		else $error("sdLba changed while a request was pending");

endmodule

bind saveSequencer saveStore_asserts seqChecks
(
	.clk_sys(clk_sys),
	.nBNKB(nBNKB),
	.sdRd(sdRd),
	.sdWr(sdWr),
	.sdAck(sdAck),
	.sdLba(sdLba)
);

// File: testbench/tbSaveStore.sv
/*
  Directed testbench for the save-storage block
  Work RAM wipe and byte lanes, arcade load and save,
  console gating, CD save file, save without an image
  Host block-device model answers with a random delay
*/

`timescale 1ns/1ps

module tbSaveStore
#(
	parameter int Seed = 49134
);

	import savePkg::*;

	localparam int WramW      = 6;
	localparam int WramWords  = 2 ** WramW;
	localparam int SectorW    = 256;
	localparam int ReqTimeout = 50;
	localparam int RunTimeout = WramWords + 20;

	logic                   clk_sys;
	logic                   nBNKB;
	logic                   sysResetReq;
	sysTypeT                systemType;
	logic                   sysRunning;
	logic [WramW-1:0]       wramAddr;
	logic                   wramWrLo;
	logic                   wramWrHi;
	logic [WordW-1:0]       wramDin;
	logic [WordW-1:0]       wramDout;
	logic [BackupAddrW-1:0] bkAddr;
	logic                   bkWrLo;
	logic                   bkWrHi;
	logic [WordW-1:0]       bkDin;
	logic [WordW-1:0]       bkDout;
	logic [CardAddrW-1:0]   cardAddr;
	logic                   cardWr;
	logic [WordW-1:0]       cardDin;
	logic [WordW-1:0]       cardDout;
	logic                   downloading;
	logic                   imgReady;
	logic                   saveReq;
	logic [LbaW-1:0]        sdLba;
	logic                   sdRd;
	logic                   sdWr;
	logic                   sdAck;
	logic [BuffAddrW-1:0]   sdBuffAddr;
	logic [WordW-1:0]       sdBuffDout;
	logic                   sdBuffWr;
	logic [WordW-1:0]       sdBuffDin;

	// Expected memory contents
	logic [WordW-1:0] wramModel [WramWords];
	logic [WordW-1:0] bkModel   [2 ** BackupAddrW];
	logic [WordW-1:0] cardModel [2 ** CardAddrW];

	// Type taken by the last wipe
	sysTypeT latchedType;
	integer  seed;

	tbClock clkGen (.clk_sys(clk_sys));

	saveStoreTop #(.WramAddrW(WramW)) dut
	(
		.clk_sys(clk_sys), .nBNKB(nBNKB),
		.sysResetReq(sysResetReq), .systemType(systemType), .sysRunning(sysRunning),
		.wramAddr(wramAddr), .wramWrLo(wramWrLo), .wramWrHi(wramWrHi),
		.wramDin(wramDin), .wramDout(wramDout),
		.bkAddr(bkAddr), .bkWrLo(bkWrLo), .bkWrHi(bkWrHi),
		.bkDin(bkDin), .bkDout(bkDout),
		.cardAddr(cardAddr), .cardWr(cardWr), .cardDin(cardDin), .cardDout(cardDout),
		.downloading(downloading), .imgReady(imgReady), .saveReq(saveReq),
		.sdLba(sdLba), .sdRd(sdRd), .sdWr(sdWr), .sdAck(sdAck),
		.sdBuffAddr(sdBuffAddr), .sdBuffDout(sdBuffDout),
		.sdBuffWr(sdBuffWr), .sdBuffDin(sdBuffDin)
	);

	// ========================================
	// Helpers
	// ========================================

	task automatic failRun(input string line);
		$display("%s", line);
		$display("*** TEST FAILED ***");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Host file word, sector and offset folded into one 16-bit value
	function automatic logic [WordW-1:0] patternWord(input int lba, input int addr);
		return WordW'(lba * SectorW + addr) ^ 16'hA5A5;
	endfunction

	function automatic logic [WordW-1:0] mergeLanes(input logic [WordW-1:0] old,
		input logic [WordW-1:0] din, input logic lo, input logic hi);
		logic [WordW-1:0] res;
		res = old;
		if (lo)
			res[7:0] = din[7:0];
		if (hi)
			res[15:8] = din[15:8];
		return res;
	endfunction

	// Word the sequencer must read back for a save
	function automatic logic [WordW-1:0] modelWord(input int lba, input int addr);
		if (latchedType[1])
			return cardModel[lba * SectorW + addr];
		else if (lba >= BackupSectors)
			return cardModel[(lba - BackupSectors) * SectorW + addr];
		else
			return bkModel[lba * SectorW + addr];
	endfunction

	task automatic waitRunning(output int cycles);
		cycles = 0;
		while (!sysRunning)
		begin
			if (cycles >= RunTimeout)
				failRun("Timeout: sysRunning did not rise after the work RAM wipe");
			else
			begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	// Pulse the reset request and wait for the wipe to finish
	task automatic resetRequest(input sysTypeT newType);
		int cycles;
		systemType  = newType;
		sysResetReq = 1'b1;
		@(negedge clk_sys);
		assert (sysRunning === 1'b0)
			else failRun($sformatf("Mismatch at %0t: sysRunning still high in reset", $time));
		repeat (3) @(negedge clk_sys);
		sysResetReq = 1'b0;
		@(negedge clk_sys);
		waitRunning(cycles);
		assert (cycles == WramWords)
			else failRun($sformatf("Mismatch at %0t: wipe ended after %0d cycles, expected %0d",
				$time, cycles, WramWords));
		latchedType = newType;
		for (int i = 0; i < WramWords; i++)
			wramModel[i] = WordW'(i);
	endtask

	task automatic writeWram(input int addr, input logic [WordW-1:0] data,
		input logic lo, input logic hi);
		wramAddr = WramW'(addr);
		wramDin  = data;
		wramWrLo = lo;
		wramWrHi = hi;
		@(negedge clk_sys);
		wramWrLo = 1'b0;
		wramWrHi = 1'b0;
		wramModel[addr] = mergeLanes(wramModel[addr], data, lo, hi);
	endtask

	task automatic checkWramAll();
		for (int i = 0; i < WramWords; i++)
		begin
			wramAddr = WramW'(i);
			@(negedge clk_sys);
			assert (wramDout === wramModel[i])
				else failRun($sformatf("Mismatch at %0t: work RAM %0d read %h, expected %h",
					$time, i, wramDout, wramModel[i]));
		end
	endtask

	// Backup CPU writes only land on MVS
	task automatic writeBackup(input int addr, input logic [WordW-1:0] data,
		input logic lo, input logic hi);
		bkAddr = BackupAddrW'(addr);
		bkDin  = data;
		bkWrLo = lo;
		bkWrHi = hi;
		@(negedge clk_sys);
		bkWrLo = 1'b0;
		bkWrHi = 1'b0;
		if (latchedType == sysArcade)
			bkModel[addr] = mergeLanes(bkModel[addr], data, lo, hi);
	endtask

	task automatic writeCard(input int addr, input logic [WordW-1:0] data);
		cardAddr = CardAddrW'(addr);
		cardDin  = data;
		cardWr   = 1'b1;
		@(negedge clk_sys);
		cardWr = 1'b0;
		cardModel[addr] = data;
	endtask

	task automatic checkBackupAll();
		for (int i = 0; i < 2 ** BackupAddrW; i++)
		begin
			bkAddr = BackupAddrW'(i);
			@(negedge clk_sys);
			assert (bkDout === bkModel[i])
				else failRun($sformatf("Mismatch at %0t: backup word %0d read %h, expected %h",
					$time, i, bkDout, bkModel[i]));
		end
	endtask

	task automatic checkCardRange(input int words);
		for (int i = 0; i < words; i++)
		begin
			cardAddr = CardAddrW'(i);
			@(negedge clk_sys);
			assert (cardDout === cardModel[i])
				else failRun($sformatf("Mismatch at %0t: card word %0d read %h, expected %h",
					$time, i, cardDout, cardModel[i]));
		end
	endtask

	// ========================================
	// Host block-device model
	// ========================================

	task automatic waitRequest();
		int cycles;
		cycles = 0;
		while (!(sdRd || sdWr))
		begin
			if (cycles >= ReqTimeout)
				failRun("Timeout: no sector request from the sequencer");
			else
			begin
				@(negedge clk_sys);
				cycles++;
			end
		end
	endtask

	// Serve every sector of one load or save, in LBA order
	task automatic serveTransfer(input logic isLoad, input int sectors);
		int               delay;
		logic [WordW-1:0] expWord;
		for (int lba = 0; lba < sectors; lba++)
		begin
			waitRequest();
			assert ((sdRd === isLoad) && (sdWr === !isLoad))
				else failRun($sformatf("Mismatch at %0t: request rd=%b wr=%b at LBA %0d",
					$time, sdRd, sdWr, lba));
			assert (sdLba === LbaW'(lba))
				else failRun($sformatf("Mismatch at %0t: sdLba %0d, expected %0d",
					$time, sdLba, lba));
			// Back-pressure, request must stay up meanwhile
			delay = $random(seed) & 7;
			for (int d = 0; d < delay; d++)
			begin
				@(negedge clk_sys);
				assert ((sdRd === isLoad) && (sdWr === !isLoad))
					else failRun($sformatf("Mismatch at %0t: request dropped before sdAck at LBA %0d",
						$time, lba));
			end
			for (int a = 0; a < SectorW; a++)
			begin
				sdAck      = 1'b1;
				sdBuffAddr = BuffAddrW'(a);
				sdBuffWr   = isLoad;
				sdBuffDout = patternWord(lba, a);
				@(negedge clk_sys);
				if (isLoad)
				begin
					if (latchedType[1])
						cardModel[lba * SectorW + a] = patternWord(lba, a);
					else if (lba >= BackupSectors)
						cardModel[(lba - BackupSectors) * SectorW + a] = patternWord(lba, a);
					else if (latchedType == sysArcade)
						bkModel[lba * SectorW + a] = patternWord(lba, a);
				end
				else
				begin
					// Read data trails the buffer address by one cycle
					expWord = modelWord(lba, a);
					assert (sdBuffDin === expWord)
						else failRun($sformatf("Mismatch at %0t: LBA %0d word %0d got %h, expected %h",
							$time, lba, a, sdBuffDin, expWord));
				end
			end
			sdAck    = 1'b0;
			sdBuffWr = 1'b0;
			@(negedge clk_sys);
		end
	endtask

	// No request may follow the last sector
	task automatic checkQuiet(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			assert (!(sdRd || sdWr))
				else failRun($sformatf("Mismatch at %0t: unexpected request at LBA %0d",
					$time, sdLba));
			@(negedge clk_sys);
		end
	endtask

	task automatic startLoad();
		downloading = 1'b1;
		repeat (4) @(negedge clk_sys);
		downloading = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic pulseSave();
		saveReq = 1'b1;
		repeat (2) @(negedge clk_sys);
		saveReq = 1'b0;
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic testWipe();
		int cycles;
		waitRunning(cycles);
		assert (cycles == WramWords)
			else failRun($sformatf("Mismatch at %0t: first wipe took %0d cycles, expected %0d",
				$time, cycles, WramWords));
		checkWramAll();
		writeWram(3, 16'hBEEF, 1'b1, 1'b1);
		writeWram(40, 16'h1357, 1'b1, 1'b1);
		checkWramAll();
		// Second wipe restores the address pattern
		resetRequest(sysArcade);
		checkWramAll();
	endtask

	task automatic testByteLanes();
		writeWram(5, 16'h1234, 1'b1, 1'b1);
		writeWram(5, 16'hABCD, 1'b1, 1'b0);
		writeWram(9, 16'h5AF0, 1'b0, 1'b1);
		writeWram(63, 16'hC3C3, 1'b1, 1'b0);
		checkWramAll();
	endtask

	task automatic testArcadeLoad();
		startLoad();
		serveTransfer(1'b1, CartSectors);
		checkQuiet(20);
		checkBackupAll();
		checkCardRange((CartSectors - BackupSectors) * SectorW);
	endtask

	task automatic testArcadeSave();
		writeBackup(0, 16'h0F0F, 1'b1, 1'b1);
		writeBackup(1234, 16'h8001, 1'b1, 1'b0);
		writeBackup(32767, 16'h7E00, 1'b0, 1'b1);
		writeCard(7, 16'hCAFE);
		writeCard(1023, 16'h600D);
		pulseSave();
		serveTransfer(1'b0, CartSectors);
		checkQuiet(20);
		// Console: backup RAM must ignore CPU writes and loads
		resetRequest(sysConsole);
		writeBackup(1234, 16'hFFFF, 1'b1, 1'b1);
		startLoad();
		serveTransfer(1'b1, CartSectors);
		checkQuiet(20);
		checkBackupAll();
		checkCardRange((CartSectors - BackupSectors) * SectorW);
	endtask

	task automatic testCdSystem();
		resetRequest(sysCd);
		startLoad();
		serveTransfer(1'b1, CdSectors);
		checkQuiet(20);
		checkCardRange(2 ** CardAddrW);
		checkBackupAll();
		writeCard(300, 16'h2468);
		writeCard(4095, 16'h9BDF);
		pulseSave();
		serveTransfer(1'b0, CdSectors);
		checkQuiet(20);
	endtask

	task automatic testSaveNoImage();
		imgReady = 1'b0;
		repeat (3) @(negedge clk_sys);
		saveReq = 1'b1;
		checkQuiet(2000);
		saveReq  = 1'b0;
		imgReady = 1'b1;
		@(negedge clk_sys);
	endtask

	initial
	begin
		seed        = Seed;
		nBNKB       = 1'b0;
		sysResetReq = 1'b0;
		systemType  = sysArcade;
		latchedType = sysArcade;
		wramAddr    = '0;
		wramWrLo    = 1'b0;
		wramWrHi    = 1'b0;
		wramDin     = '0;
		bkAddr      = '0;
		bkWrLo      = 1'b0;
		bkWrHi      = 1'b0;
		bkDin       = '0;
		cardAddr    = '0;
		cardWr      = 1'b0;
		cardDin     = '0;
		downloading = 1'b0;
		imgReady    = 1'b1;
		saveReq     = 1'b0;
		sdAck       = 1'b0;
		sdBuffAddr  = '0;
		sdBuffDout  = '0;
		sdBuffWr    = 1'b0;
		for (int i = 0; i < WramWords; i++)
			wramModel[i] = WordW'(i);

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		nBNKB = 1'b1;

		testWipe();
		testByteLanes();
		testArcadeLoad();
		testArcadeSave();
		testCdSystem();
		testSaveNoImage();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: verilog.f
hdl/savePkg.sv
hdl/saveRam.sv
hdl/resetWiper.sv
hdl/workRam.sv
hdl/saveSequencer.sv
hdl/saveStoreTop.sv
testbench/tbClock.sv
testbench/saveStore_asserts.sv
testbench/tbSaveStore.sv

// File: Makefile
# Verilator build and run of the save-storage testbench
# Override any variable on the command line, e.g. make sim SEED=7

VERILATOR ?= verilator
TOP       ?= tbSaveStore
SEED      ?= 49134
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# A failing run exits non-zero, so make fails with it
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -GSeed=$(SEED) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
